// File: files.f
link_pkg.sv
uart_tx.sv
uart_rx.sv
link_tx_arbiter.sv
link_decoder.sv
link_top.sv
link_chk.sv
tb_link_top.sv

// File: Bender.yml
package:
  name: penalty_link

sources:
  - link_pkg.sv
  - uart_tx.sv
  - uart_rx.sv
  - link_tx_arbiter.sv
  - link_decoder.sv
  - link_top.sv
  - target: test
    files:
      - link_chk.sv
      - tb_link_top.sv

// File: tb_link_top.sv
// Testbench for the game board message link.
// Four master models post bytes from a table. In loopback mode the serial
// output feeds the receiver. In direct mode a serial driver sends frames,
// a bad stop bit among them. A model of the opponent record is compared
// with the DUT on every cycle.

`default_nettype none

module tb_link_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CPB     = link_pkg::CLKS_PER_BIT;
    localparam int N_ENT   = 4;
    localparam int TIMEOUT = N_ENT * 4 * 12 * CPB + 2000;  // plus margin for direct mode

    typedef struct packed {
        logic [3:0]                mask;   // masters that post
        logic [3:0]                late;   // these start mid-frame
        link_pkg::link_msg_t [3:0] msg;
        logic [3:0][1:0]           order;  // expected ack order starting at [0]
        logic [2:0]                n_msg;
    } entry_t;

    logic clk, reset, loopback, ser_line, tx_line, rx_line, msg_valid, frame_err;
    logic [3:0] wb_ack;
    link_pkg::wb_req_t       wb_req [0:link_pkg::N_SOURCES-1];
    link_pkg::remote_state_t remote, model_remote;
    link_pkg::link_event_t   events, exp_ev;
    link_pkg::link_msg_t     exp_q[$];
    entry_t                  entries [N_ENT];
    int ack_src_q[$], ack_cyc_q[$];
    int cycles, err_cnt;
    integer seed;

    assign rx_line = loopback ? tx_line : ser_line;

    link_top dut0 (.clk, .reset, .wb_req, .wb_ack, .tx(tx_line), .rx(rx_line),
                   .remote, .events, .msg_valid, .frame_err);

    always #5 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic link_pkg::link_msg_t pack_msg(input link_pkg::msg_op_t op, input int pl);
        return '{payload: 5'(pl), op: op};
    endfunction

    // expected effect of one received byte
    task automatic apply_msg(input link_pkg::link_msg_t m);
        case (m.op)
            link_pkg::OP_CONNECT: model_remote.connected  = m.payload[0];
            link_pkg::OP_KEEPER:  model_remote.keeper_pos = m.payload;
            link_pkg::OP_SHOT_X:  model_remote.shot_x     = m.payload;
            link_pkg::OP_SHOT_Y:  model_remote.shot_y     = m.payload;
            link_pkg::OP_SCORE:   model_remote.score      = m.payload[2:0];
            link_pkg::OP_EVENT:   exp_ev = {m.payload[0], m.payload[1], m.payload[2]};
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
            abort_run($sformatf("Timeout: run still busy after %0d cycles", TIMEOUT));
    end

    // scoreboard sampled mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            exp_ev = '0;
            if (frame_err)
                err_cnt++;
            if (msg_valid && exp_q.size() == 0) begin
                abort_run("A message was decoded that nobody had sent");
            end else begin
                if (msg_valid)
                    apply_msg(exp_q.pop_front());
                check("remote", remote, model_remote);
                check("events", events, exp_ev);
            end
        end
    end

    // holds cyc and stb until ack, then releases
    task automatic run_master(input int m, input entry_t e);
        if (e.mask[m]) begin
            if (e.late[m])
                repeat (3 * CPB) @(posedge clk);
            @(posedge clk);
            #1 wb_req[m] = '{cyc: 1'b1, stb: 1'b1, dat: e.msg[m]};
            do @(negedge clk); while (!wb_ack[m]);
            ack_src_q.push_back(m);
            ack_cyc_q.push_back(cycles);
            exp_q.push_back(e.msg[m]);
            @(posedge clk);
            #1 wb_req[m] = '0;
        end
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    task automatic run_entry(input entry_t e);
        ack_src_q.delete();
        ack_cyc_q.delete();
        fork
            run_master(0, e);
            run_master(1, e);
            run_master(2, e);
            run_master(3, e);
        join
        wait_drain();
        check("ack count", ack_src_q.size(), e.n_msg);
        for (int k = 0; k < e.n_msg; k++) begin
            check("ack source", ack_src_q[k], e.order[k]);
            if (k > 0)  // next ack only once the frame is out
                check("ack gap ok", (ack_cyc_q[k] - ack_cyc_q[k-1]) >= 10 * CPB, 1);
        end
    endtask

    task automatic send_frame(input logic [7:0] b, input logic stop);
        logic [9:0] frame;
        frame = {stop, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(posedge clk);
            #1 ser_line = frame[i];
            repeat (CPB - 1) @(posedge clk);
        end
        @(posedge clk);
        #1 ser_line = 1'b1;
        repeat (2 * CPB) @(posedge clk);  // idle gap
    endtask

    initial begin
        link_pkg::link_msg_t m;
        clk          = 1'b0;
        reset        = 1'b1;
        loopback     = 1'b0;
        ser_line     = 1'b1;
        cycles       = 0;
        err_cnt      = 0;
        seed         = 32'hd827;
        model_remote = '0;
        exp_ev       = '0;
        for (int i = 0; i < link_pkg::N_SOURCES; i++)
            wb_req[i] = '0;
        // masters 3 down to 0
        entries[0] = '{mask: 4'hf, late: 4'h0, order: {2'd3, 2'd2, 2'd1, 2'd0}, n_msg: 3'd4,
            msg: {pack_msg(link_pkg::OP_SHOT_Y, 7), pack_msg(link_pkg::OP_SHOT_X, 22),
                  pack_msg(link_pkg::OP_KEEPER, 13), pack_msg(link_pkg::OP_CONNECT, 1)}};
        entries[1] = '{mask: 4'h2, late: 4'h0, order: {2'd0, 2'd0, 2'd0, 2'd1}, n_msg: 3'd1,
            msg: {8'h00, 8'h00, pack_msg(link_pkg::OP_SCORE, 5), 8'h00}};
        entries[2] = '{mask: 4'hf, late: 4'h0, order: {2'd1, 2'd0, 2'd3, 2'd2}, n_msg: 3'd4,
            msg: {pack_msg(link_pkg::OP_SCORE, 30), pack_msg(link_pkg::OP_SHOT_X, 0),
                  pack_msg(link_pkg::OP_KEEPER, 31), pack_msg(link_pkg::OP_EVENT, 3)}};
        entries[3] = '{mask: 4'h5, late: 4'h4, order: {2'd0, 2'd0, 2'd2, 2'd0}, n_msg: 3'd2,
            msg: {8'h00, pack_msg(link_pkg::OP_EVENT, 4), 8'h00,
                  pack_msg(link_pkg::OP_SHOT_Y, 18)}};
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        loopback = 1'b1;  // serial output feeds the receiver
        @(negedge clk);
        check("outputs after reset", {tx_line, wb_ack, msg_valid, events, frame_err, remote},
              {1'b1, 28'h0});
        for (int i = 0; i < N_ENT; i++)
            run_entry(entries[i]);
        loopback = 1'b0;  // testbench drives rx from here on
        m = pack_msg(link_pkg::OP_KEEPER, $random(seed));
        exp_q.push_back(m);
        send_frame(m, 1'b1);
        send_frame(pack_msg(link_pkg::OP_SHOT_X, $random(seed)), 1'b0);  // low stop bit
        check("frame_err count", err_cnt, 1);
        send_frame({5'($random(seed)), 3'd6}, 1'b1);
        send_frame({5'($random(seed)), 3'd7}, 1'b1);
        m = pack_msg(link_pkg::OP_CONNECT, 0);
        exp_q.push_back(m);
        send_frame(m, 1'b1);
        wait_drain();
        check("frame_err count", err_cnt, 1);
        if (dut0.chk0.fail_cnt == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            abort_run("The protocol checker flagged assertion failures");
        end
    end

endmodule

`default_nettype wire

// File: link_chk.sv
// Protocol assertions for the message link, bound into link_top.
// Covers one ack at a time, the one-cycle slave ack, an idle-high
// serial line and exclusive receive outcomes.

`default_nettype none

module link_chk (
    input logic                              clk,
    input logic                              reset,
    input logic [link_pkg::N_SOURCES-1:0]    wb_ack,
    input logic                              bus_ack,
    input logic                              tx,
    input link_pkg::tx_state_t               tx_state,
    input logic                              msg_valid,
    input logic                              frame_err
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_cnt = 0;  // failed assertions so far

    one_ack: assert property (@(posedge clk) disable iff (reset) $onehot0(wb_ack))
        else begin
            fail_cnt++;
            $error("more than one master acknowledged");
        end

    short_ack: assert property (@(posedge clk) disable iff (reset) bus_ack |=> !bus_ack)
        else begin
            fail_cnt++;
            $error("transmitter ack longer than one cycle");
        end

    idle_high: assert property (@(posedge clk) disable iff (reset)
        tx_state == link_pkg::TX_IDLE |-> tx)
        else begin
            fail_cnt++;
            $error("serial line low while transmitter idle");
        end

    rx_excl: assert property (@(posedge clk) disable iff (reset) !(msg_valid && frame_err))
        else begin
            fail_cnt++;
            $error("message and frame error in the same cycle");
        end

endmodule

bind link_top link_chk chk0 (.clk(clk), .reset(reset), .wb_ack(wb_ack), .bus_ack(bus_ack),
    .tx(tx), .tx_state(u_uart_tx.state), .msg_valid(msg_valid), .frame_err(frame_err));

`default_nettype wire

// File: link_top.sv
// Top of the message link between the two game boards.
// Four game blocks post bytes as Wishbone masters; the arbiter hands the
// single transmitter to one of them at a time. Incoming serial bytes are
// decoded into the opponent record and event pulses.

`default_nettype none

module link_top (
    input  logic                              clk,
    input  logic                              reset,
    input  link_pkg::wb_req_t                 wb_req [0:link_pkg::N_SOURCES-1],
    output logic [link_pkg::N_SOURCES-1:0]    wb_ack,
    output logic                              tx,
    input  logic                              rx,
    output link_pkg::remote_state_t           remote,
    output link_pkg::link_event_t             events,
    output logic                              msg_valid,
    output logic                              frame_err
);

    link_pkg::wb_req_t   bus_req;
    logic                bus_ack;
    logic                byte_valid;
    link_pkg::link_msg_t byte_data;

    link_tx_arbiter u_link_tx_arbiter (
        .clk,
        .reset,
        .wb_req,
        .bus_ack,
        .wb_ack,
        .bus_req
    );

    uart_tx u_uart_tx (
        .clk,
        .reset,
        .bus_req,
        .bus_ack,
        .tx
    );

    uart_rx u_uart_rx (
        .clk,
        .reset,
        .rx,
        .byte_valid,
        .byte_data,
        .frame_err
    );

    link_decoder u_link_decoder (
        .clk,
        .reset,
        .byte_valid,
        .byte_data,
        .remote,
        .events,
        .msg_valid
    );

endmodule

`default_nettype wire

// File: link_decoder.sv
// Decoder for bytes arriving from the other board.
// The opcode selects which field of the opponent record takes the
// payload, or which event pulses fire. The update is registered and
// msg_valid pulses with it one cycle after byte_valid.
// Codes outside the opcode list are dropped without a msg_valid.

`default_nettype none

module link_decoder (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    byte_valid,
    input  link_pkg::link_msg_t     byte_data,
    output link_pkg::remote_state_t remote,
    output link_pkg::link_event_t   events,
    output logic                    msg_valid
);

    logic [4:0] payload;

    assign payload = byte_data.payload;

    always_ff @(posedge clk) begin
        if (reset) begin
            remote    <= '0;
            events    <= '0;
            msg_valid <= 1'b0;
        end else begin
            events    <= '0;  // pulses by default
            msg_valid <= 1'b0;
            if (byte_valid) begin
                case (byte_data.op)
                    link_pkg::OP_CONNECT: begin
                        remote.connected <= payload[0];
                        msg_valid        <= 1'b1;
                    end
                    link_pkg::OP_KEEPER: begin
                        remote.keeper_pos <= payload;
                        msg_valid         <= 1'b1;
                    end
                    link_pkg::OP_SHOT_X: begin
                        remote.shot_x <= payload;
                        msg_valid     <= 1'b1;
                    end
                    link_pkg::OP_SHOT_Y: begin
                        remote.shot_y <= payload;
                        msg_valid     <= 1'b1;
                    end
                    link_pkg::OP_SCORE: begin
                        remote.score <= payload[2:0];  // score fits in 3 bits
                        msg_valid    <= 1'b1;
                    end
                    link_pkg::OP_EVENT: begin
                        events.shot_taken    <= payload[0];
                        events.is_scored     <= payload[1];
                        events.back_to_start <= payload[2];
                        msg_valid            <= 1'b1;
                    end
                    default: ;  // codes 6 and 7 change nothing
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// File: link_tx_arbiter.sv
// Round-robin arbiter in front of the shared transmitter.
// With no grant active it picks the first master showing cyc and stb,
// starting one past the last winner. The grant is registered and held
// until the winner drops cyc, so a master waiting out a frame keeps the
// bus. The slave's ack goes back to the granted master only.

`default_nettype none

module link_tx_arbiter (
    input  logic                              clk,
    input  logic                              reset,
    input  link_pkg::wb_req_t                 wb_req [0:link_pkg::N_SOURCES-1],
    input  logic                              bus_ack,
    output logic [link_pkg::N_SOURCES-1:0]    wb_ack,
    output link_pkg::wb_req_t                 bus_req
);

    logic                       grant_valid;
    logic [link_pkg::SRC_W-1:0] grant_idx;
    logic [link_pkg::SRC_W-1:0] next_idx;   // search start

    logic                       pick_found;
    logic [link_pkg::SRC_W-1:0] pick_idx;

    // priority search from next_idx with the index wrapping by width
    always_comb begin
        logic [link_pkg::SRC_W-1:0] offs;
        logic [link_pkg::SRC_W-1:0] idx;
        pick_found = 1'b0;
        pick_idx   = next_idx;
        for (int i = 0; i < link_pkg::N_SOURCES; i++) begin
            offs = i[link_pkg::SRC_W-1:0];
            idx  = next_idx + offs;
            if (!pick_found && wb_req[idx].cyc && wb_req[idx].stb) begin
                pick_found = 1'b1;
                pick_idx   = idx;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            grant_valid <= 1'b0;
            grant_idx   <= '0;
            next_idx    <= '0;
        end else if (grant_valid) begin
            if (!wb_req[grant_idx].cyc)
                grant_valid <= 1'b0;  // cycle over
        end else if (pick_found) begin
            grant_valid <= 1'b1;
            grant_idx   <= pick_idx;
            next_idx    <= pick_idx + 1'b1;
        end
    end

    // shared bus mux
    always_comb begin
        bus_req = '0;
        if (grant_valid)
            bus_req = wb_req[grant_idx];
    end

    // ack routing
    always_comb begin
        wb_ack = '0;
        if (grant_valid)
            wb_ack[grant_idx] = bus_ack;
    end

endmodule

`default_nettype wire

// File: uart_rx.sv
// 8N1 serial receiver.
// The line is synchronised, a falling edge arms the start check and the
// start bit is confirmed at half a bit. Data bits are then sampled at
// mid-bit, LSB first. A high stop bit gives a byte_valid pulse with the
// byte; a low one gives a frame_err pulse and the byte is dropped.

`default_nettype none

module uart_rx (
    input  logic                clk,
    input  logic                reset,
    input  logic                rx,
    output logic                byte_valid,
    output link_pkg::link_msg_t byte_data,
    output logic                frame_err
);

    link_pkg::rx_state_t state;

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;  // for edge detect
    logic fall;

    logic [link_pkg::BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]                     bit_idx;
    logic [7:0]                     shreg;

    assign fall = rx_prev && !rx_sync;

    // two flop synchroniser that idles high
    always_ff @(posedge clk) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= link_pkg::RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
            clk_cnt    <= clk_cnt + 1'b1;
            case (state)
                link_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (fall)
                        state <= link_pkg::RX_START;
                end
                link_pkg::RX_START: begin
                    if (clk_cnt == link_pkg::HALF_TICK) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        // glitch if the line is back high
                        state   <= rx_sync ? link_pkg::RX_IDLE : link_pkg::RX_DATA;
                    end
                end
                link_pkg::RX_DATA: begin
                    if (clk_cnt == link_pkg::LAST_TICK) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= link_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (clk_cnt == link_pkg::LAST_TICK) begin
                        byte_valid <= rx_sync;
                        frame_err  <= !rx_sync;
                        state      <= link_pkg::RX_IDLE;
                    end
                end
            endcase
        end
    end

    // data shifter and output byte
    always_ff @(posedge clk) begin
        if (state == link_pkg::RX_DATA && clk_cnt == link_pkg::LAST_TICK)
            shreg <= {rx_sync, shreg[7:1]};
        if (state == link_pkg::RX_STOP && clk_cnt == link_pkg::LAST_TICK && rx_sync)
            byte_data <= link_pkg::link_msg_t'(shreg);
    end

endmodule

`default_nettype wire

// File: uart_tx.sv
// 8N1 serial transmitter with a Wishbone classic slave front end.
// A byte is taken only while idle; the ack pulses for one cycle and the
// start bit follows in the next cycle. A request that shows up mid-frame
// simply waits on the bus until the line is free again.

`default_nettype none

module uart_tx (
    input  logic              clk,
    input  logic              reset,
    input  link_pkg::wb_req_t bus_req,
    output logic              bus_ack,
    output logic              tx
);

    link_pkg::tx_state_t state;

    logic [link_pkg::BIT_CNT_W-1:0] clk_cnt;
    logic [2:0]                     bit_idx;
    logic [7:0]                     shreg;

    logic take;     // new byte accepted this cycle
    logic bit_end;  // last cycle of a bit period

    assign take    = (state == link_pkg::TX_IDLE) && bus_req.cyc && bus_req.stb;
    assign bit_end = (clk_cnt == link_pkg::LAST_TICK);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= link_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
            bus_ack <= 1'b0;
            tx      <= 1'b1;
        end else begin
            bus_ack <= 1'b0;
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                link_pkg::TX_IDLE: begin
                    tx      <= 1'b1;
                    clk_cnt <= '0;
                    if (take) begin
                        bus_ack <= 1'b1;
                        state   <= link_pkg::TX_START;
                    end
                end
                link_pkg::TX_START: begin
                    tx <= 1'b0;
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= link_pkg::TX_DATA;
                    end
                end
                link_pkg::TX_DATA: begin
                    tx <= shreg[0];  // lsb first
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7)
                            state <= link_pkg::TX_STOP;
                    end
                end
                default: begin
                    tx <= 1'b1;  // stop bit
                    if (bit_end)
                        state <= link_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // payload shifter
    always_ff @(posedge clk) begin
        if (take)
            shreg <= bus_req.dat;
        else if (state == link_pkg::TX_DATA && bit_end)
            shreg <= {1'b0, shreg[7:1]};
    end

endmodule

`default_nettype wire

// File: link_pkg.sv
// Shared definitions for the inter-board message link of the shootout game.
// Holds the message opcodes, the byte layout, the Wishbone request bundle,
// the opponent record, the event pulses and the serial timing constants.
// Every other file refers to these by scoped names.

`default_nettype none

package link_pkg;

    // number of game blocks posting messages
    localparam int N_SOURCES = 4;
    localparam int SRC_W     = $clog2(N_SOURCES);

    // clock cycles per serial bit
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    localparam logic [BIT_CNT_W-1:0] LAST_TICK = BIT_CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [BIT_CNT_W-1:0] HALF_TICK = BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);

    // message opcodes in the low 3 bits of every byte
    typedef enum logic [2:0] {
        OP_CONNECT = 3'd0,  // payload[0] peer ready
        OP_KEEPER  = 3'd1,
        OP_SHOT_X  = 3'd2,
        OP_SHOT_Y  = 3'd3,
        OP_SCORE   = 3'd4,
        OP_EVENT   = 3'd5   // payload[2:0] back_to_start, is_scored, shot_taken
    } msg_op_t;

    typedef struct packed {
        logic [4:0] payload;
        msg_op_t    op;
    } link_msg_t;

    // one master's classic single write request
    typedef struct packed {
        logic      cyc;
        logic      stb;
        link_msg_t dat;
    } wb_req_t;

    // what we know about the other board
    typedef struct packed {
        logic       connected;
        logic [4:0] keeper_pos;
        logic [4:0] shot_x;
        logic [4:0] shot_y;
        logic [2:0] score;
    } remote_state_t;

    // single cycle pulses
    typedef struct packed {
        logic shot_taken;
        logic is_scored;
        logic back_to_start;
    } link_event_t;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_t;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

endpackage

`default_nettype wire
